/* hw/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ********************
// Widths
// ********************
`define RV_XLEN             32          // Data word width
`define RV_REG_AW           5           // Register file address width
`define RV_MEM_AW           16          // Data memory address width

// ********************
// Opcodes
// ********************
`define RV_OPC_OP           7'b011_0011 // Register-register ALU
`define RV_OPC_OP_IMM       7'b001_0011 // Register-immediate ALU
`define RV_OPC_LOAD         7'b000_0011
`define RV_OPC_STORE        7'b010_0011

// ALU funct3 values
`define RV_F3_ADD           3'b000      // ADD, SUB, ADDI
`define RV_F3_SLL           3'b001
`define RV_F3_SLT           3'b010
`define RV_F3_SLTU          3'b011
`define RV_F3_XOR           3'b100
`define RV_F3_SR            3'b101      // SRL and SRA, split by bit 30
`define RV_F3_OR            3'b110
`define RV_F3_AND           3'b111

// Load and store size funct3 values
`define RV_F3_B             3'b000
`define RV_F3_H             3'b001
`define RV_F3_W             3'b010
`define RV_F3_BU            3'b100
`define RV_F3_HU            3'b101

// ********************
// ALU and memory op codes
// ********************
`define RV_ALU_NOP          4'd0        // Result forced to zero
`define RV_ALU_ADD          4'd1
`define RV_ALU_SUB          4'd2
`define RV_ALU_SLL          4'd3
`define RV_ALU_SLT          4'd4
`define RV_ALU_SLTU         4'd5
`define RV_ALU_XOR          4'd6
`define RV_ALU_SRL          4'd7
`define RV_ALU_SRA          4'd8
`define RV_ALU_OR           4'd9
`define RV_ALU_AND          4'd10

`define RV_MEM_NOP          2'd0
`define RV_MEM_LOAD         2'd1
`define RV_MEM_STORE        2'd2

`endif

/* hw/rv_core_top.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_top
    import rv_pkg::*;
(
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  logic [`RV_XLEN-1:0]   inst_data,
    output logic [`RV_XLEN-1:0]   inst_addr,
    output logic [`RV_MEM_AW-1:0] mem_addr,
    output logic                  mem_wr,
    output logic [`RV_XLEN-1:0]   mem_wdata,
    input  logic [`RV_XLEN-1:0]   mem_rdata
);

    logic [`RV_XLEN-1:0]   pc;
    rv_inst_u              ir;              // Instruction register
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  wr_en;
    logic [`RV_REG_AW-1:0] wr_addr;
    logic [`RV_XLEN-1:0]   wr_data;
    rv_dec_ex_s            dec_ex;
    rv_ex_mem_s            ex_mem;
    rv_mem_wb_s            mem_wb;

    // ********************
    // Fetch
    // ********************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            pc <= '0;
            ir <= '0;                               // Bubble
        end else begin
            pc <= pc + `RV_XLEN'd4;                 // No branches, always sequential
            ir <= inst_data;
        end
    end

    assign inst_addr = pc;

    rv_reg_file u_reg_file (
        .CK_REF(CK_REF), .RST_N(RST_N),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    rv_decode u_decode (
        .CK_REF(CK_REF), .RST_N(RST_N), .inst(ir),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .dec_ex(dec_ex)
    );

    rv_execute u_execute (
        .CK_REF(CK_REF), .RST_N(RST_N), .dec_ex(dec_ex), .ex_mem(ex_mem)
    );

    rv_mem_access u_mem_access (
        .CK_REF(CK_REF), .RST_N(RST_N), .ex_mem(ex_mem),
        .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_wdata(mem_wdata),
        .mem_wb(mem_wb)
    );

    rv_writeback u_writeback (
        .mem_wb(mem_wb), .mem_rdata(mem_rdata),   // Read data is valid one cycle after address
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  rv_inst_u              inst,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output rv_dec_ex_s            dec_ex
);

    rv_dec_ex_s          dec_nxt;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic                valid;     // Word decoded to a supported instruction
    logic                is_op;     // Register-register form

    assign rs1_addr = inst.r.rs1;   // Same field position in all three formats
    assign rs2_addr = inst.r.rs2;   // Unused read for I-type is harmless

    assign imm_i = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign is_op = (inst.r.opcode == `RV_OPC_OP);

    // ********************
    // Instruction decode
    // ********************
    always_comb begin
        dec_nxt        = '0;
        dec_nxt.op_a   = rs1_data;
        dec_nxt.rd     = inst.r.rd;
        dec_nxt.size   = inst.r.funct3;
        valid          = 1'b0;
        case (inst.r.opcode)
            `RV_OPC_OP, `RV_OPC_OP_IMM: begin
                valid         = 1'b1;                   // Every funct3 is an ALU function
                dec_nxt.wb_en = 1'b1;
                dec_nxt.op_b  = is_op ? rs2_data : imm_i;
                case (inst.r.funct3)
                    `RV_F3_ADD:  dec_nxt.alu_op = (is_op && inst.r.funct7[5]) ?
                                                  `RV_ALU_SUB : `RV_ALU_ADD;  // No SUBI
                    `RV_F3_SLL:  dec_nxt.alu_op = `RV_ALU_SLL;
                    `RV_F3_SLT:  dec_nxt.alu_op = `RV_ALU_SLT;
                    `RV_F3_SLTU: dec_nxt.alu_op = `RV_ALU_SLTU;
                    `RV_F3_XOR:  dec_nxt.alu_op = `RV_ALU_XOR;
                    `RV_F3_SR:   dec_nxt.alu_op = inst.r.funct7[5] ?
                                                  `RV_ALU_SRA : `RV_ALU_SRL;  // Bit 30
                    `RV_F3_OR:   dec_nxt.alu_op = `RV_ALU_OR;
                    default:     dec_nxt.alu_op = `RV_ALU_AND;
                endcase
            end
            `RV_OPC_LOAD: begin
                valid = (inst.i.funct3 == `RV_F3_B)  || (inst.i.funct3 == `RV_F3_H) ||
                        (inst.i.funct3 == `RV_F3_W)  || (inst.i.funct3 == `RV_F3_BU) ||
                        (inst.i.funct3 == `RV_F3_HU);
                dec_nxt.alu_op = `RV_ALU_ADD;           // Address = rs1 + imm
                dec_nxt.op_b   = imm_i;
                dec_nxt.wb_en  = 1'b1;
                dec_nxt.mem_op = `RV_MEM_LOAD;
            end
            `RV_OPC_STORE: begin
                valid = (inst.s.funct3 == `RV_F3_B) || (inst.s.funct3 == `RV_F3_H) ||
                        (inst.s.funct3 == `RV_F3_W);
                dec_nxt.alu_op     = `RV_ALU_ADD;
                dec_nxt.op_b       = imm_s;             // Split immediate
                dec_nxt.rd         = '0;                // No rd field in S-type
                dec_nxt.mem_op     = `RV_MEM_STORE;
                dec_nxt.store_data = rs2_data;
            end
            default: ;                                  // Bubble or unknown opcode
        endcase
        if (!valid) begin
            dec_nxt = '0;                               // Everything off
        end
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            dec_ex <= '0;
        end else begin
            dec_ex <= dec_nxt;
        end
    end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic       CK_REF,
    input  logic       RST_N,
    input  rv_dec_ex_s dec_ex,
    output rv_ex_mem_s ex_mem
);

    logic [`RV_XLEN-1:0] alu_res;
    logic [4:0]          shamt;

    assign shamt = dec_ex.op_b[4:0];    // Upper bits of operand b ignored

    // ********************
    // ALU
    // ********************
    always_comb begin
        case (dec_ex.alu_op)
            `RV_ALU_ADD:  alu_res = dec_ex.op_a + dec_ex.op_b;
            `RV_ALU_SUB:  alu_res = dec_ex.op_a - dec_ex.op_b;
            `RV_ALU_SLL:  alu_res = dec_ex.op_a << shamt;
            `RV_ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}},
                                     ($signed(dec_ex.op_a) < $signed(dec_ex.op_b))};
            `RV_ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, (dec_ex.op_a < dec_ex.op_b)};
            `RV_ALU_XOR:  alu_res = dec_ex.op_a ^ dec_ex.op_b;
            `RV_ALU_SRL:  alu_res = dec_ex.op_a >> shamt;
            `RV_ALU_SRA:  alu_res = $unsigned($signed(dec_ex.op_a) >>> shamt);  // Keeps sign
            `RV_ALU_OR:   alu_res = dec_ex.op_a | dec_ex.op_b;
            `RV_ALU_AND:  alu_res = dec_ex.op_a & dec_ex.op_b;
            default:      alu_res = '0;                 // NOP from a bubble
        endcase
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.result     <= alu_res;
            ex_mem.rd         <= dec_ex.rd;             // Control fields pass through
            ex_mem.wb_en      <= dec_ex.wb_en;
            ex_mem.mem_op     <= dec_ex.mem_op;
            ex_mem.size       <= dec_ex.size;
            ex_mem.store_data <= dec_ex.store_data;
        end
    end

endmodule

/* hw/rv_mem_access.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_mem_access
    import rv_pkg::*;
(
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  rv_ex_mem_s            ex_mem,
    output logic [`RV_MEM_AW-1:0] mem_addr,
    output logic                  mem_wr,
    output logic [`RV_XLEN-1:0]   mem_wdata,
    output rv_mem_wb_s            mem_wb
);

    logic                is_load;
    logic                is_store;
    logic [`RV_XLEN-1:0] st_data;   // Store data narrowed to the access size

    assign is_load  = (ex_mem.mem_op == `RV_MEM_LOAD);
    assign is_store = (ex_mem.mem_op == `RV_MEM_STORE);

    // ********************
    // Store data narrowing
    // ********************
    always_comb begin
        case (ex_mem.size)
            `RV_F3_B: st_data = {{(`RV_XLEN-8){ex_mem.store_data[7]}}, ex_mem.store_data[7:0]};
            `RV_F3_H: st_data = {{(`RV_XLEN-16){ex_mem.store_data[15]}},
                                 ex_mem.store_data[15:0]};
            default:  st_data = ex_mem.store_data;      // SW, whole word
        endcase
    end

    // Bus is quiet unless a load or store is in this stage
    assign mem_addr  = (is_load || is_store) ? ex_mem.result[`RV_MEM_AW-1:0] : '0;
    assign mem_wr    = is_store;                        // Memory writes at the closing edge
    assign mem_wdata = is_store ? st_data : '0;

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.result  <= ex_mem.result;
            mem_wb.rd      <= ex_mem.rd;
            mem_wb.wb_en   <= ex_mem.wb_en;
            mem_wb.is_load <= is_load;                  // Read data arrives next cycle
            mem_wb.size    <= ex_mem.size;
        end
    end

endmodule

/* hw/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    // ********************
    // Instruction word views
    // ********************
    typedef struct packed {
        logic [6:0]            funct7;      // Bit 30 selects SUB and SRA
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } rv_inst_r_s;

    typedef struct packed {
        logic [11:0]           imm;         // Sign bit at the top
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } rv_inst_i_s;

    typedef struct packed {
        logic [6:0]            imm_hi;      // Immediate bits 11..5
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;      // Immediate bits 4..0
        logic [6:0]            opcode;
    } rv_inst_s_s;

    typedef union packed {
        rv_inst_r_s r;
        rv_inst_i_s i;
        rv_inst_s_s s;
    } rv_inst_u;

    // ********************
    // Pipeline bundles
    // ********************
    typedef struct packed {
        logic [3:0]            alu_op;
        logic [`RV_XLEN-1:0]   op_a;        // rs1 data
        logic [`RV_XLEN-1:0]   op_b;        // rs2 data or immediate
        logic [`RV_REG_AW-1:0] rd;
        logic                  wb_en;
        logic [1:0]            mem_op;
        logic [2:0]            size;        // funct3 of a load or store
        logic [`RV_XLEN-1:0]   store_data;
    } rv_dec_ex_s;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_REG_AW-1:0] rd;
        logic                  wb_en;
        logic [1:0]            mem_op;
        logic [2:0]            size;
        logic [`RV_XLEN-1:0]   store_data;
    } rv_ex_mem_s;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_REG_AW-1:0] rd;
        logic                  wb_en;
        logic                  is_load;     // Take memory data at write back
        logic [2:0]            size;
    } rv_mem_wb_s;

endpackage

/* hw/rv_reg_file.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_reg_file (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wr_en,
    input  logic [`RV_REG_AW-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]   wr_data
);

    logic [`RV_XLEN-1:0] regs [1:(2**`RV_REG_AW)-1];  // x0 has no storage

    // ********************
    // Write port
    // ********************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            for (int i = 1; i < 2**`RV_REG_AW; i++) begin
                regs[i] <= '0;                          // Architectural state starts clean
            end
        end else if (wr_en && (wr_addr != '0)) begin    // Writes to x0 dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // Read ports, combinational, no bypass
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hw/rv_writeback.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_writeback
    import rv_pkg::*;
(
    input  rv_mem_wb_s            mem_wb,
    input  logic [`RV_XLEN-1:0]   mem_rdata,
    output logic                  wr_en,
    output logic [`RV_REG_AW-1:0] wr_addr,
    output logic [`RV_XLEN-1:0]   wr_data
);

    logic [`RV_XLEN-1:0] ld_data;   // Load data after extension
    logic [`RV_XLEN-1:0] wb_data;

    // ********************
    // Load extension
    // ********************
    always_comb begin
        case (mem_wb.size)
            `RV_F3_B:  ld_data = {{(`RV_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
            `RV_F3_H:  ld_data = {{(`RV_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
            `RV_F3_BU: ld_data = {{(`RV_XLEN-8){1'b0}}, mem_rdata[7:0]};
            `RV_F3_HU: ld_data = {{(`RV_XLEN-16){1'b0}}, mem_rdata[15:0]};
            default:   ld_data = mem_rdata;             // LW
        endcase
    end

    assign wb_data = mem_wb.is_load ? ld_data : mem_wb.result;

    assign wr_en   = mem_wb.wb_en;
    assign wr_addr = mem_wb.wb_en ? mem_wb.rd : '0;     // Parked on x0 when idle
    assign wr_data = mem_wb.wb_en ? wb_data : '0;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrv_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_reg_file.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_access.sv
hw/rv_writeback.sv
hw/rv_core_top.sv
verif/rv_core_sva.sv
verif/rv_core_tb.sv

/* verif/rv_core_sva.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_sva (
    input logic                  CK_REF,
    input logic                  RST_N,
    input logic [`RV_REG_AW-1:0] rs1_addr,
    input logic [`RV_REG_AW-1:0] rs2_addr,
    input logic [`RV_XLEN-1:0]   rs1_data,
    input logic [`RV_XLEN-1:0]   rs2_data,
    input logic [`RV_XLEN-1:0]   inst_addr,
    input logic                  mem_wr
);

    // ********************
    // Register file read ports
    // ********************
    x0_rs1_zero: assert property (@(posedge CK_REF) (rs1_addr == '0) |-> (rs1_data == '0))
        else $error("x0 read nonzero on rs1 port");
    x0_rs2_zero: assert property (@(posedge CK_REF) (rs2_addr == '0) |-> (rs2_data == '0))
        else $error("x0 read nonzero on rs2 port");

    // ********************
    // Fetch and data bus
    // ********************
    pc_step: assert property (@(posedge CK_REF) disable iff (!RST_N)
                              $past(RST_N) |-> (inst_addr == $past(inst_addr) + `RV_XLEN'd4))
        else $error("inst_addr did not advance by 4");
    wr_known: assert property (@(posedge CK_REF) !$isunknown(mem_wr))
        else $error("mem_wr is unknown");

endmodule

// Read ports seen at the core level, where the register file is wired up
bind rv_core_top rv_core_sva u_sva (
    .CK_REF(CK_REF), .RST_N(RST_N),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .inst_addr(inst_addr), .mem_wr(mem_wr)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int n_inst    = 300;                     // Random instructions
    localparam int n_total   = n_inst + 31;             // Plus the final register dump
    localparam int dump_base = 512;                     // Dump area, clear of random stores
    localparam logic [2:0] ld_sizes [0:4] = '{`RV_F3_B, `RV_F3_H, `RV_F3_W,
                                              `RV_F3_BU, `RV_F3_HU};

    logic                  CK_REF;
    logic                  RST_N;
    logic [`RV_XLEN-1:0]   inst_data;
    logic [`RV_XLEN-1:0]   inst_addr;
    logic [`RV_MEM_AW-1:0] mem_addr;
    logic                  mem_wr;
    logic [`RV_XLEN-1:0]   mem_wdata;
    logic [`RV_XLEN-1:0]   mem_rdata;

    logic [`RV_XLEN-1:0] arch_regs [0:31];              // Architectural register model
    logic [`RV_XLEN-1:0] arch_mem [0:1023];             // Memory as the program sees it
    logic [`RV_XLEN-1:0] bus_mem [0:1023];              // Memory behind the DUT bus
    logic [`RV_XLEN-1:0] exp_addr_q [$];                // Expected stores in program order
    logic [`RV_XLEN-1:0] exp_data_q [$];
    logic [`RV_XLEN-1:0] exp_pc;
    int                  store_cnt;

    rv_core_top UUT (
        .CK_REF(CK_REF), .RST_N(RST_N),
        .inst_data(inst_data), .inst_addr(inst_addr),
        .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    // ********************
    // Reference model
    // ********************
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            `RV_F3_ADD:  return alt ? (a - b) : (a + b);
            `RV_F3_SLL:  return a << sh;
            `RV_F3_SLT:  return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};  // Sign first
            `RV_F3_SLTU: return {31'd0, (a < b)};
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SR:   return (a >> sh) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> sh));
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    // Byte and half sizes sign or zero extend, used for loads and store narrowing
    function automatic logic [31:0] extend_to_word(input logic [2:0] f3, input logic [31:0] w);
        case (f3)
            `RV_F3_B:  return {{24{w[7]}}, w[7:0]};
            `RV_F3_H:  return {{16{w[15]}}, w[15:0]};
            `RV_F3_BU: return {24'd0, w[7:0]};
            `RV_F3_HU: return {16'd0, w[15:0]};
            default:   return w;
        endcase
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [2:0] f3);
        rv_inst_u w;
        w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: 5'd0, funct3: f3,
                imm_lo: imm[4:0], opcode: `RV_OPC_STORE};      // Base is always x0
        return w;
    endfunction

    // ********************
    // Checks
    // ********************
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s = %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // ********************
    // Stimulus
    // ********************
    task automatic issue(input logic [31:0] word);
        @(posedge CK_REF);
        inst_data <= word;
    endtask

    task automatic issue_spaced(input logic [31:0] word);
        issue(word);
        repeat (3) issue('0);                           // No hazard logic in the core
    endtask

    task automatic random_inst();
        rv_inst_u    w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        logic [31:0] val;
        logic [31:0] addr;
        int unsigned kind;
        kind = $urandom % 10;
        f3   = 3'($urandom);
        rd   = 5'($urandom);                            // x0 included on purpose
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        imm  = 12'($urandom);
        alt  = 1'($urandom);
        addr = {24'd0, imm[7:2], 2'b00};                // Word aligned, below 256
        w    = '0;
        val  = '0;
        if (kind < 3) begin                             // Register-register
            alt = alt && (f3 == `RV_F3_ADD || f3 == `RV_F3_SR);
            w.r = '{funct7: {1'b0, alt, 5'd0}, rs2: rs2, rs1: rs1, funct3: f3,
                    rd: rd, opcode: `RV_OPC_OP};
            val = alu_result(f3, alt, arch_regs[rs1], arch_regs[rs2]);
        end else if (kind < 6) begin                    // Register-immediate
            alt = alt && (f3 == `RV_F3_SR);
            if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR) begin
                imm = {1'b0, alt, 5'd0, imm[4:0]};      // Shift amount form
            end
            w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: `RV_OPC_OP_IMM};
            val = alu_result(f3, alt, arch_regs[rs1], {{20{imm[11]}}, imm});
        end else if (kind < 8) begin                    // Load
            f3  = ld_sizes[$urandom % 5];
            w.i = '{imm: addr[11:0], rs1: 5'd0, funct3: f3, rd: rd, opcode: `RV_OPC_LOAD};
            val = extend_to_word(f3, arch_mem[addr[11:2]]);
        end else if (kind == 8) begin                   // Store
            f3  = 3'($urandom % 3);
            val = extend_to_word(f3, arch_regs[rs2]);
            w   = store_word(addr[11:0], rs2, f3);
            arch_mem[addr[11:2]] = val;                 // Whole bus word lands in memory
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(val);
        end else if (alt) begin                         // Word the core must ignore
            w          = $urandom;
            w.r.opcode = f3[0] ? 7'b011_0111 : `RV_OPC_LOAD;
            if (!f3[0]) begin
                w.i.funct3 = 3'b111;                    // No such load size
            end
        end
        if (kind < 8 && rd != '0) begin
            arch_regs[rd] = val;
        end
        issue_spaced(w);
    endtask

    task automatic dump_reg(input logic [4:0] r);
        logic [11:0] imm;
        imm = 12'(dump_base + 4 * r);
        exp_addr_q.push_back({20'd0, imm});
        exp_data_q.push_back(arch_regs[r]);
        issue_spaced(store_word(imm, r, `RV_F3_W));
    endtask

    // ********************
    // Clock, memory and bus monitor
    // ********************
    initial begin
        CK_REF = 1'b0;
        forever #5 CK_REF = ~CK_REF;
    end

    always @(posedge CK_REF) begin
        mem_rdata <= bus_mem[mem_addr[11:2]];           // Word at the previous cycle's address
        if (RST_N) begin
            check_value("inst_addr", inst_addr, exp_pc);
            exp_pc = exp_pc + 32'd4;
            if (mem_wr === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    stop_on_error($sformatf("Unexpected store on the bus at %0t ns", $time));
                end else begin
                    check_value("mem_addr", 32'(mem_addr), exp_addr_q.pop_front());
                    check_value("mem_wdata", mem_wdata, exp_data_q.pop_front());
                    bus_mem[mem_addr[11:2]] = mem_wdata;
                    store_cnt++;
                end
            end else begin
                check_value("mem_wr", 32'(mem_wr), 32'd0);      // Also catches X
                check_value("mem_wdata", mem_wdata, 32'd0);     // Quiet bus
            end
        end
    end

    initial begin
        #((n_total * 4 + 200) * 10);
        stop_on_error("Timeout, the program did not drain in the expected time");
    end

    // ********************
    // Main sequence
    // ********************
    initial begin
        void'($urandom(32'h1fc8));
        RST_N     = 1'b0;
        inst_data = '0;
        mem_rdata = '0;
        exp_pc    = '0;
        store_cnt = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            arch_mem[i] = $urandom;                     // Same random contents in both views
            bus_mem[i]  = arch_mem[i];
        end
        repeat (10) @(posedge CK_REF);
        check_value("inst_addr", inst_addr, 32'd0);
        check_value("mem_wr", 32'(mem_wr), 32'd0);
        RST_N <= 1'b1;
        for (int n = 0; n < n_inst; n++) begin
            random_inst();
        end
        for (int r = 1; r < 32; r++) begin
            dump_reg(5'(r));                            // Register state becomes visible
        end
        repeat (8) issue('0);                           // Drain the pipeline
        if (exp_addr_q.size() == 0) begin
            $display("%0d stores checked", store_cnt);
            $display("Verification passed");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected stores never reached the bus",
                                    exp_addr_q.size()));
        end
    end

endmodule
